// ==== verilog/mipsCtrlPkg.sv ====
`default_nettype none

package mipsCtrlPkg;

    localparam int stateW = 5;
    localparam int classW = 4;

    // one IR word, read as R-format or I-format depending on the opcode
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rFormat;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iFormat;
    } instrWord_u;

    localparam logic [stateW-1:0] stFetchRead   = 5'd0;
    localparam logic [stateW-1:0] stFetchPc     = 5'd1;
    localparam logic [stateW-1:0] stFetchLatch  = 5'd2;
    localparam logic [stateW-1:0] stDecodeRegs  = 5'd3;
    localparam logic [stateW-1:0] stDecodeLatch = 5'd4;
    localparam logic [stateW-1:0] stExecute     = 5'd5;
    localparam logic [stateW-1:0] stRWrite      = 5'd6;
    localparam logic [stateW-1:0] stIWrite      = 5'd7;
    localparam logic [stateW-1:0] stSltWrite    = 5'd8;
    localparam logic [stateW-1:0] stShiftRun    = 5'd9;
    localparam logic [stateW-1:0] stShiftWrite  = 5'd10;
    localparam logic [stateW-1:0] stXchgFirst   = 5'd11;
    localparam logic [stateW-1:0] stXchgSecond  = 5'd12;
    localparam logic [stateW-1:0] stBreakPc     = 5'd13;
    localparam logic [stateW-1:0] stCloseWrite  = 5'd14;
    localparam logic [stateW-1:0] stWaitFinal   = 5'd15;

    localparam logic [classW-1:0] clsAluR     = 4'd0;
    localparam logic [classW-1:0] clsSlt      = 4'd1;
    localparam logic [classW-1:0] clsShiftImm = 4'd2;
    localparam logic [classW-1:0] clsShiftVar = 4'd3;
    localparam logic [classW-1:0] clsJr       = 4'd4;
    localparam logic [classW-1:0] clsRte      = 4'd5;
    localparam logic [classW-1:0] clsBreak    = 4'd6;
    localparam logic [classW-1:0] clsXchg     = 4'd7;
    localparam logic [classW-1:0] clsAddi     = 4'd8; // addi and addiu
    localparam logic [classW-1:0] clsIllegal  = 4'd9;

    localparam logic [5:0] opRType = 6'd0;
    localparam logic [5:0] opAddi  = 6'd8;
    localparam logic [5:0] opAddiu = 6'd9;

    localparam logic [5:0] fnSll   = 6'd0;
    localparam logic [5:0] fnSrl   = 6'd2;
    localparam logic [5:0] fnSra   = 6'd3;
    localparam logic [5:0] fnSllv  = 6'd4;
    localparam logic [5:0] fnXchg  = 6'd5;
    localparam logic [5:0] fnSrav  = 6'd7;
    localparam logic [5:0] fnJr    = 6'd8;
    localparam logic [5:0] fnBreak = 6'd13;
    localparam logic [5:0] fnRte   = 6'd19;
    localparam logic [5:0] fnAdd   = 6'd32;
    localparam logic [5:0] fnSub   = 6'd34;
    localparam logic [5:0] fnAnd   = 6'd36;
    localparam logic [5:0] fnSlt   = 6'd42;

    localparam logic [2:0] aluPass = 3'd0;
    localparam logic [2:0] aluAdd  = 3'd1;
    localparam logic [2:0] aluSub  = 3'd2;
    localparam logic [2:0] aluAnd  = 3'd3;
    localparam logic [2:0] aluSlt  = 3'd7;

    localparam logic [2:0] shNone       = 3'd0;
    localparam logic [2:0] shLoad       = 3'd1; // load shifter from its sources
    localparam logic [2:0] shLeft       = 3'd2;
    localparam logic [2:0] shRightLog   = 3'd3;
    localparam logic [2:0] shRightArith = 3'd4;

    localparam logic [1:0] srcAPc    = 2'd0;
    localparam logic [1:0] srcARegA  = 2'd1;
    localparam logic [1:0] srcBRegB  = 2'd0;
    localparam logic [1:0] srcBFour  = 2'd1;
    localparam logic [1:0] srcBImm   = 2'd2;
    localparam logic [1:0] srcBOffset = 2'd3; // branch offset, shifted

    localparam logic [1:0] pcFromAlu = 2'd0;
    localparam logic [1:0] pcFromEpc = 2'd3;

    localparam logic [2:0] dstRt = 3'd0;
    localparam logic [2:0] dstRd = 3'd1;
    localparam logic [2:0] dstRs = 3'd4;

    localparam logic [3:0] wbAluOut   = 4'd0;
    localparam logic [3:0] wbLessThan = 4'd4;
    localparam logic [3:0] wbShiftReg = 4'd7;
    localparam logic [3:0] wbXchgReg  = 4'd8;

endpackage

`default_nettype wire

// ==== verilog/ctrlIfs.sv ====
`default_nettype none

// sequencer state and latched decode, shared by both encoders
interface seqIf
    import mipsCtrlPkg::*;
();
    logic [stateW-1:0] state;
    logic [classW-1:0] instrClass;
    logic [2:0]        aluOp;
    logic [2:0]        shiftOp;

    modport source (output state, instrClass, aluOp, shiftOp);
    modport sink   (input  state, instrClass, aluOp, shiftOp);
endinterface

interface aluCtrlIf;
    logic [2:0] aluControl;
    logic [1:0] aluSrcA;
    logic [1:0] aluSrcB;
    logic       aluOutWrite;
    logic [2:0] shiftControl;
    logic       shiftSrcA;
    logic       shiftSrcB;

    modport source (output aluControl, aluSrcA, aluSrcB, aluOutWrite,
                           shiftControl, shiftSrcA, shiftSrcB);
    modport sink   (input  aluControl, aluSrcA, aluSrcB, aluOutWrite,
                           shiftControl, shiftSrcA, shiftSrcB);
endinterface

interface wbCtrlIf;
    logic       regWrite;
    logic [2:0] regDst;
    logic [3:0] memToReg;
    logic       xchgCtrl;
    logic       xchgSrc;
    logic       irWrite;
    logic       pcWrite;
    logic [1:0] pcSource;

    modport source (output regWrite, regDst, memToReg, xchgCtrl, xchgSrc,
                           irWrite, pcWrite, pcSource);
    modport sink   (input  regWrite, regDst, memToReg, xchgCtrl, xchgSrc,
                           irWrite, pcWrite, pcSource);
endinterface

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`default_nettype none

module instrDecoder
    import mipsCtrlPkg::*;
(
    input  instrWord_u        instr,
    output logic [classW-1:0] instrClass,
    output logic [2:0]        aluOp,
    output logic [2:0]        shiftOp
);

    always_comb begin
        instrClass = clsIllegal;
        aluOp      = aluAdd;
        shiftOp    = shNone;
        if (instr.iFormat.opcode == opAddi || instr.iFormat.opcode == opAddiu) begin
            instrClass = clsAddi; // same path, overflow handled in the ALU
        end else if (instr.iFormat.opcode == opRType) begin
            case (instr.rFormat.funct)
                fnAdd: instrClass = clsAluR;
                fnSub: begin
                    instrClass = clsAluR;
                    aluOp      = aluSub;
                end
                fnAnd: begin
                    instrClass = clsAluR;
                    aluOp      = aluAnd;
                end
                fnSlt: begin
                    instrClass = clsSlt;
                    aluOp      = aluSlt;
                end
                fnSll: begin
                    instrClass = clsShiftImm;
                    shiftOp    = shLeft;
                end
                fnSrl: begin
                    instrClass = clsShiftImm;
                    shiftOp    = shRightLog;
                end
                fnSra: begin
                    instrClass = clsShiftImm;
                    shiftOp    = shRightArith;
                end
                fnSllv: begin
                    instrClass = clsShiftVar;
                    shiftOp    = shLeft;
                end
                fnSrav: begin
                    instrClass = clsShiftVar;
                    shiftOp    = shRightArith;
                end
                fnJr:    instrClass = clsJr;
                fnRte:   instrClass = clsRte;
                fnBreak: instrClass = clsBreak;
                fnXchg:  instrClass = clsXchg;
                default: instrClass = clsIllegal;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/controlSequencer.sv ====
`default_nettype none

module controlSequencer
    import mipsCtrlPkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [classW-1:0] instrClass,
    input  logic [2:0]        aluOp,
    input  logic [2:0]        shiftOp,
    seqIf.source              seq
);

    logic [stateW-1:0] nextState;

    always_comb begin
        nextState = stFetchRead;
        case (seq.state)
            stFetchRead:   nextState = stFetchPc;
            stFetchPc:     nextState = stFetchLatch;
            stFetchLatch:  nextState = stDecodeRegs;
            stDecodeRegs:  nextState = stDecodeLatch;
            stDecodeLatch: nextState = stExecute;
            stExecute: begin
                case (seq.instrClass)
                    clsAluR:     nextState = stRWrite;
                    clsAddi:     nextState = stIWrite;
                    clsSlt:      nextState = stSltWrite;
                    clsShiftImm: nextState = stShiftRun;
                    clsShiftVar: nextState = stShiftRun;
                    clsXchg:     nextState = stXchgFirst;
                    clsBreak:    nextState = stBreakPc;
                    default:     nextState = stCloseWrite; // jr, rte, unknown words
                endcase
            end
            stShiftRun:  nextState = stShiftWrite;
            stXchgFirst: nextState = stXchgSecond;
            stRWrite,
            stIWrite,
            stSltWrite,
            stShiftWrite,
            stXchgSecond,
            stBreakPc:    nextState = stCloseWrite;
            stCloseWrite: nextState = stWaitFinal;
            default:      nextState = stFetchRead;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            seq.state      <= stFetchRead;
            seq.instrClass <= clsIllegal;
        end else begin
            seq.state <= nextState;
            if (seq.state == stDecodeLatch)
                seq.instrClass <= instrClass; // IR is stable from here on
        end
    end

    // only read once instrClass says they are valid
    always_ff @(posedge clk) begin
        if (seq.state == stDecodeLatch) begin
            seq.aluOp   <= aluOp;
            seq.shiftOp <= shiftOp;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/aluShiftControl.sv ====
`default_nettype none

module aluShiftControl
    import mipsCtrlPkg::*;
(
    seqIf.sink       seq,
    aluCtrlIf.source alu
);

    logic shiftByImm; // shamt field rather than rs

    assign shiftByImm = (seq.instrClass == clsShiftImm);

    always_comb begin
        alu.aluControl   = aluPass;
        alu.aluSrcA      = srcAPc;
        alu.aluSrcB      = srcBRegB;
        alu.aluOutWrite  = 1'b0;
        alu.shiftControl = shNone;
        alu.shiftSrcA    = 1'b0;
        alu.shiftSrcB    = 1'b0;
        case (seq.state)
            stFetchRead, stFetchPc, stFetchLatch: begin
                alu.aluControl = aluAdd; // pc + 4
                alu.aluSrcB    = srcBFour;
            end
            stDecodeRegs, stDecodeLatch: begin
                alu.aluControl  = aluAdd; // branch target, speculative
                alu.aluSrcB     = srcBOffset;
                alu.aluOutWrite = (seq.state == stDecodeRegs);
            end
            stExecute: begin
                case (seq.instrClass)
                    clsAluR: begin
                        alu.aluControl  = seq.aluOp;
                        alu.aluSrcA     = srcARegA;
                        alu.aluOutWrite = 1'b1;
                    end
                    clsAddi: begin
                        alu.aluControl  = aluAdd;
                        alu.aluSrcA     = srcARegA;
                        alu.aluSrcB     = srcBImm;
                        alu.aluOutWrite = 1'b1;
                    end
                    clsSlt: begin
                        alu.aluControl = aluSlt;
                        alu.aluSrcA    = srcARegA;
                    end
                    clsJr:   alu.aluSrcA = srcARegA; // rs passes to pc
                    clsBreak: begin
                        alu.aluControl = aluSub;
                        alu.aluSrcB    = srcBFour;
                    end
                    clsShiftImm, clsShiftVar: begin
                        alu.shiftControl = shLoad;
                        alu.shiftSrcA    = shiftByImm;
                        alu.shiftSrcB    = shiftByImm;
                    end
                    default: ;
                endcase
            end
            stShiftRun: begin
                alu.shiftControl = seq.shiftOp;
                alu.shiftSrcA    = shiftByImm;
                alu.shiftSrcB    = shiftByImm;
            end
            stSltWrite: begin
                alu.aluControl = aluSlt; // hold compare for the lt flag
                alu.aluSrcA    = srcARegA;
            end
            stBreakPc: begin
                alu.aluControl = aluSub; // undo the fetch increment
                alu.aluSrcB    = srcBFour;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/writebackControl.sv ====
`default_nettype none

module writebackControl
    import mipsCtrlPkg::*;
(
    seqIf.sink      seq,
    wbCtrlIf.source wb
);

    always_comb begin
        wb.regWrite = 1'b0;
        wb.regDst   = dstRt;
        wb.memToReg = wbAluOut;
        wb.xchgCtrl = 1'b0;
        wb.xchgSrc  = 1'b0;
        wb.irWrite  = 1'b0;
        wb.pcWrite  = 1'b0;
        wb.pcSource = pcFromAlu;
        case (seq.state)
            stFetchPc:    wb.pcWrite = 1'b1;
            stFetchLatch: wb.irWrite = 1'b1;
            stExecute: begin
                case (seq.instrClass)
                    clsJr: wb.pcWrite = 1'b1;
                    clsRte: begin
                        wb.pcWrite  = 1'b1;
                        wb.pcSource = pcFromEpc;
                    end
                    clsXchg: wb.xchgCtrl = 1'b1; // capture both regs
                    default: ;
                endcase
            end
            stRWrite: begin
                wb.regWrite = 1'b1;
                wb.regDst   = dstRd;
            end
            stIWrite: wb.regWrite = 1'b1; // rt gets aluOut
            stSltWrite: begin
                wb.regWrite = 1'b1;
                wb.regDst   = dstRd;
                wb.memToReg = wbLessThan;
            end
            stShiftWrite: begin
                wb.regWrite = 1'b1;
                wb.regDst   = dstRd;
                wb.memToReg = wbShiftReg;
            end
            stXchgFirst: begin
                wb.regWrite = 1'b1;
                wb.memToReg = wbXchgReg; // old rs into rt
            end
            stXchgSecond: begin
                wb.regWrite = 1'b1;
                wb.regDst   = dstRs;
                wb.memToReg = wbXchgReg;
                wb.xchgSrc  = 1'b1;
            end
            stBreakPc: wb.pcWrite = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/mipsControlUnit.sv ====
`default_nettype none

module mipsControlUnit
    import mipsCtrlPkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [31:0]       instr,
    output logic [stateW-1:0] state,
    output logic [2:0]        aluControl,
    output logic [2:0]        shiftControl,
    output logic [2:0]        regDst,
    output logic [1:0]        aluSrcA,
    output logic [1:0]        aluSrcB,
    output logic [1:0]        pcSource,
    output logic [3:0]        memToReg,
    output logic              aluOutWrite,
    output logic              shiftSrcA,
    output logic              shiftSrcB,
    output logic              regWrite,
    output logic              irWrite,
    output logic              pcWrite,
    output logic              xchgCtrl,
    output logic              xchgSrc
);

    logic [classW-1:0] decClass;
    logic [2:0]        decAluOp;
    logic [2:0]        decShiftOp;

    seqIf     seqBus ();
    aluCtrlIf aluBus ();
    wbCtrlIf  wbBus ();

    instrDecoder decoder0 (
        .instr      (instr),
        .instrClass (decClass),
        .aluOp      (decAluOp),
        .shiftOp    (decShiftOp)
    );

    controlSequencer sequencer0 (
        .clk        (clk),
        .reset      (reset),
        .instrClass (decClass),
        .aluOp      (decAluOp),
        .shiftOp    (decShiftOp),
        .seq        (seqBus.source)
    );

    aluShiftControl aluCtrl0 (
        .seq (seqBus.sink),
        .alu (aluBus.source)
    );

    writebackControl wbCtrl0 (
        .seq (seqBus.sink),
        .wb  (wbBus.source)
    );

    assign state        = seqBus.state;
    assign aluControl   = aluBus.aluControl;
    assign aluSrcA      = aluBus.aluSrcA;
    assign aluSrcB      = aluBus.aluSrcB;
    assign aluOutWrite  = aluBus.aluOutWrite;
    assign shiftControl = aluBus.shiftControl;
    assign shiftSrcA    = aluBus.shiftSrcA;
    assign shiftSrcB    = aluBus.shiftSrcB;
    assign regWrite     = wbBus.regWrite;
    assign regDst       = wbBus.regDst;
    assign memToReg     = wbBus.memToReg;
    assign xchgCtrl     = wbBus.xchgCtrl;
    assign xchgSrc      = wbBus.xchgSrc;
    assign irWrite      = wbBus.irWrite;
    assign pcWrite      = wbBus.pcWrite;
    assign pcSource     = wbBus.pcSource;

endmodule

`default_nettype wire

// ==== verification/clkGen.sv ====
`default_nettype none

module clkGen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== verification/controlUnit_sva.sv ====
`default_nettype none

module controlUnitSva
    import mipsCtrlPkg::*;
(
    input logic              clk,
    input logic              reset,
    input logic [stateW-1:0] state,
    input logic              irWrite,
    input logic              regWrite,
    input logic              pcWrite,
    input logic              aluOutWrite,
    input logic              xchgCtrl
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount; // failed assertions so far

    irOnlyInLatch: assert property (@(posedge clk) disable iff (reset)
        irWrite |-> state == stFetchLatch)
        else begin
            failCount++;
            $error("irWrite set outside stFetchLatch");
        end

    waitThenFetch: assert property (@(posedge clk) disable iff (reset)
        state == stWaitFinal |=> state == stFetchRead)
        else begin
            failCount++;
            $error("stWaitFinal not followed by stFetchRead");
        end

    // register file and pc never written in one cycle
    noRegAndPc: assert property (@(posedge clk) disable iff (reset)
        !(regWrite && pcWrite))
        else begin
            failCount++;
            $error("regWrite and pcWrite set together");
        end

    quietAfterReset: assert property (@(posedge clk)
        $fell(reset) |-> !(regWrite || irWrite || pcWrite || aluOutWrite || xchgCtrl))
        else begin
            failCount++;
            $error("write enable set in the cycle after reset");
        end

endmodule

bind mipsControlUnit controlUnitSva sva0 (.*);

`default_nettype wire

// ==== verification/controlUnitTb.sv ====
`default_nettype none

module controlUnitTb
    import mipsCtrlPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int numInstr  = 400;
    localparam int clkPeriod = 8;
    localparam int timeoutNs = 2 * numInstr * 10 * clkPeriod + 8 * clkPeriod;

    typedef struct packed {
        logic [2:0] aluControl;
        logic [1:0] aluSrcA;
        logic [1:0] aluSrcB;
        logic       aluOutWrite;
        logic [2:0] shiftControl;
        logic       shiftSrcA;
        logic       shiftSrcB;
    } aluCtrl_t;

    typedef struct packed {
        logic       regWrite;
        logic [2:0] regDst;
        logic [3:0] memToReg;
        logic       xchgCtrl;
        logic       xchgSrc;
        logic       irWrite;
        logic       pcWrite;
        logic [1:0] pcSource;
    } wbCtrl_t;

    logic clk, reset;
    logic [31:0] instr;
    logic [stateW-1:0] state;
    logic [2:0] aluControl, shiftControl, regDst;
    logic [1:0] aluSrcA, aluSrcB, pcSource;
    logic [3:0] memToReg;
    logic aluOutWrite, shiftSrcA, shiftSrcB, regWrite, irWrite, pcWrite, xchgCtrl, xchgSrc;

    integer seed;
    logic [5:0] rFuncts [0:12];
    instrWord_u nextWord;
    logic [stateW-1:0] mState; // model state and latched instruction
    logic [classW-1:0] mClass;
    instrWord_u mWord;
    int instrDone;
    int cycleCount;
    bit started;
    int valueErrors;
    int lengthErrors;

    clkGen clkGen0 (.clk(clk), .reset(reset));

    mipsControlUnit dut0 (.*);

    function automatic logic [classW-1:0] classOf(instrWord_u w);
        if (w.iFormat.opcode == opAddi || w.iFormat.opcode == opAddiu)
            return clsAddi;
        if (w.rFormat.opcode != opRType)
            return clsIllegal;
        case (w.rFormat.funct)
            fnAdd, fnSub, fnAnd: return clsAluR;
            fnSlt:               return clsSlt;
            fnSll, fnSrl, fnSra: return clsShiftImm;
            fnSllv, fnSrav:      return clsShiftVar;
            fnJr:                return clsJr;
            fnRte:               return clsRte;
            fnBreak:             return clsBreak;
            fnXchg:              return clsXchg;
            default:             return clsIllegal;
        endcase
    endfunction

    function automatic logic [stateW-1:0] nextOf(logic [stateW-1:0] st, logic [classW-1:0] cls);
        case (st)
            stExecute: begin
                case (cls)
                    clsAluR:                  return stRWrite;
                    clsAddi:                  return stIWrite;
                    clsSlt:                   return stSltWrite;
                    clsShiftImm, clsShiftVar: return stShiftRun;
                    clsXchg:                  return stXchgFirst;
                    clsBreak:                 return stBreakPc;
                    default:                  return stCloseWrite;
                endcase
            end
            stShiftRun:   return stShiftWrite;
            stXchgFirst:  return stXchgSecond;
            stCloseWrite: return stWaitFinal;
            stWaitFinal:  return stFetchRead;
            default: begin
                if (st < stExecute)
                    return st + 1'b1; // fetch and decode in order
                return stCloseWrite;
            end
        endcase
    endfunction

    function automatic int lengthOf(logic [classW-1:0] cls);
        if (cls == clsJr || cls == clsRte || cls == clsIllegal)
            return 8;
        if (cls == clsShiftImm || cls == clsShiftVar || cls == clsXchg)
            return 10;
        return 9;
    endfunction

    function automatic aluCtrl_t expectAlu(logic [stateW-1:0] st, logic [classW-1:0] cls,
                                           instrWord_u w);
        aluCtrl_t e;
        logic byImm;
        e = '0;
        byImm = (cls == clsShiftImm);
        case (st)
            stFetchRead, stFetchPc, stFetchLatch: begin
                e.aluControl = aluAdd;
                e.aluSrcB    = srcBFour;
            end
            stDecodeRegs, stDecodeLatch: begin
                e.aluControl  = aluAdd;
                e.aluSrcB     = srcBOffset;
                e.aluOutWrite = (st == stDecodeRegs);
            end
            stExecute: begin
                if (cls == clsAluR || cls == clsAddi || cls == clsSlt || cls == clsJr)
                    e.aluSrcA = srcARegA;
                if (cls == clsAluR || cls == clsAddi)
                    e.aluOutWrite = 1'b1;
                if (cls == clsAluR)
                    e.aluControl = (w.rFormat.funct == fnSub) ? aluSub :
                                   (w.rFormat.funct == fnAnd) ? aluAnd : aluAdd;
                if (cls == clsAddi) begin
                    e.aluControl = aluAdd;
                    e.aluSrcB    = srcBImm;
                end
                if (cls == clsSlt)
                    e.aluControl = aluSlt;
                if (cls == clsBreak) begin
                    e.aluControl = aluSub;
                    e.aluSrcB    = srcBFour;
                end
                if (cls == clsShiftImm || cls == clsShiftVar) begin
                    e.shiftControl = shLoad;
                    e.shiftSrcA    = byImm;
                    e.shiftSrcB    = byImm;
                end
            end
            stShiftRun: begin
                case (w.rFormat.funct)
                    fnSll, fnSllv: e.shiftControl = shLeft;
                    fnSrl:         e.shiftControl = shRightLog;
                    default:       e.shiftControl = shRightArith; // sra, srav
                endcase
                e.shiftSrcA = byImm;
                e.shiftSrcB = byImm;
            end
            stSltWrite: begin
                e.aluControl = aluSlt;
                e.aluSrcA    = srcARegA;
            end
            stBreakPc: begin
                e.aluControl = aluSub;
                e.aluSrcB    = srcBFour;
            end
            default: ;
        endcase
        return e;
    endfunction

    function automatic wbCtrl_t expectWb(logic [stateW-1:0] st, logic [classW-1:0] cls);
        wbCtrl_t e;
        e = '0;
        e.regWrite = st inside {stRWrite, stIWrite, stSltWrite, stShiftWrite,
                                stXchgFirst, stXchgSecond};
        case (st)
            stFetchPc:    e.pcWrite = 1'b1;
            stFetchLatch: e.irWrite = 1'b1;
            stExecute: begin
                e.pcWrite  = (cls == clsJr || cls == clsRte);
                e.pcSource = (cls == clsRte) ? pcFromEpc : pcFromAlu;
                e.xchgCtrl = (cls == clsXchg);
            end
            stRWrite:    e.regDst = dstRd;
            stIWrite:    e.regDst = dstRt;
            stSltWrite: begin
                e.regDst   = dstRd;
                e.memToReg = wbLessThan;
            end
            stShiftWrite: begin
                e.regDst   = dstRd;
                e.memToReg = wbShiftReg;
            end
            stXchgFirst: begin
                e.regDst   = dstRt;
                e.memToReg = wbXchgReg;
            end
            stXchgSecond: begin
                e.regDst   = dstRs;
                e.memToReg = wbXchgReg;
                e.xchgSrc  = 1'b1;
            end
            stBreakPc:   e.pcWrite = 1'b1;
            default: ;
        endcase
        return e;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        $display("** Error at %0d ns: %s expected %0h, got %0h", $time, name, expVal, actVal);
        valueErrors++;
    endtask

    task automatic checkState(input logic [stateW-1:0] e, input logic [stateW-1:0] a);
        if (a !== e)
            reportMismatch("state", e, a);
    endtask

    task automatic checkAluCtrl(input aluCtrl_t e, input aluCtrl_t a);
        if (a.aluControl !== e.aluControl)
            reportMismatch("aluControl", e.aluControl, a.aluControl);
        if (a.aluSrcA !== e.aluSrcA)
            reportMismatch("aluSrcA", e.aluSrcA, a.aluSrcA);
        if (a.aluSrcB !== e.aluSrcB)
            reportMismatch("aluSrcB", e.aluSrcB, a.aluSrcB);
        if (a.aluOutWrite !== e.aluOutWrite)
            reportMismatch("aluOutWrite", e.aluOutWrite, a.aluOutWrite);
        if (a.shiftControl !== e.shiftControl)
            reportMismatch("shiftControl", e.shiftControl, a.shiftControl);
        if (a.shiftSrcA !== e.shiftSrcA)
            reportMismatch("shiftSrcA", e.shiftSrcA, a.shiftSrcA);
        if (a.shiftSrcB !== e.shiftSrcB)
            reportMismatch("shiftSrcB", e.shiftSrcB, a.shiftSrcB);
    endtask

    task automatic checkWbCtrl(input wbCtrl_t e, input wbCtrl_t a);
        if (a.regWrite !== e.regWrite)
            reportMismatch("regWrite", e.regWrite, a.regWrite);
        if (a.regDst !== e.regDst)
            reportMismatch("regDst", e.regDst, a.regDst);
        if (a.memToReg !== e.memToReg)
            reportMismatch("memToReg", e.memToReg, a.memToReg);
        if (a.xchgCtrl !== e.xchgCtrl)
            reportMismatch("xchgCtrl", e.xchgCtrl, a.xchgCtrl);
        if (a.xchgSrc !== e.xchgSrc)
            reportMismatch("xchgSrc", e.xchgSrc, a.xchgSrc);
        if (a.irWrite !== e.irWrite)
            reportMismatch("irWrite", e.irWrite, a.irWrite);
        if (a.pcWrite !== e.pcWrite)
            reportMismatch("pcWrite", e.pcWrite, a.pcWrite);
        if (a.pcSource !== e.pcSource)
            reportMismatch("pcSource", e.pcSource, a.pcSource);
    endtask

    // three words in four come from the legal list
    task automatic drawWord(output instrWord_u w);
        logic [31:0] pick;
        w = $random(seed);
        pick = $random(seed);
        if (pick[1:0] != 2'b00) begin
            pick = pick[31:2] % 15;
            if (pick < 13) begin
                w.rFormat.opcode = opRType;
                w.rFormat.funct  = rFuncts[pick];
            end else begin
                w.iFormat.opcode = pick[0] ? opAddi : opAddiu;
            end
        end
    endtask

    initial begin
        seed = 32'h2a45c0e6;
        instr = '0;
        rFuncts = '{fnSll, fnSrl, fnSra, fnSllv, fnXchg, fnSrav, fnJr,
                    fnBreak, fnRte, fnAdd, fnSub, fnAnd, fnSlt};
    end

    always @(posedge clk) begin
        drawWord(nextWord);
        instr <= nextWord;
    end

    always @(posedge clk) begin
        if (reset) begin
            mState    <= stFetchRead;
            mClass    <= clsIllegal;
            instrDone <= 0;
        end else begin
            if (mState == stDecodeLatch) begin
                mClass <= classOf(instr);
                mWord  <= instr;
            end
            if (mState == stWaitFinal)
                instrDone <= instrDone + 1;
            mState <= nextOf(mState, mClass);
        end
    end

    // outputs are settled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            checkState(mState, state);
            checkAluCtrl(expectAlu(mState, mClass, mWord),
                         {aluControl, aluSrcA, aluSrcB, aluOutWrite,
                          shiftControl, shiftSrcA, shiftSrcB});
            checkWbCtrl(expectWb(mState, mClass),
                        {regWrite, regDst, memToReg, xchgCtrl, xchgSrc,
                         irWrite, pcWrite, pcSource});
            if (state == stFetchRead) begin
                if (started && cycleCount != lengthOf(mClass)) begin
                    $display("instruction ending at %0d ns took %0d cycles instead of %0d",
                             $time, cycleCount, lengthOf(mClass));
                    lengthErrors++;
                end
                started = 1'b1;
                cycleCount = 1;
            end else begin
                cycleCount++;
            end
        end
    end

    initial begin
        wait (instrDone == numInstr);
        @(posedge clk);
        $display("errors: %0d value mismatches, %0d length mismatches, %0d assertion failures",
                 valueErrors, lengthErrors, dut0.sva0.failCount);
        if (valueErrors == 0 && lengthErrors == 0 && dut0.sva0.failCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("run timed out after %0d ns with %0d of %0d instructions done",
                 timeoutNs, instrDone, numInstr);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/mipsCtrlPkg.sv
verilog/ctrlIfs.sv
verilog/instrDecoder.sv
verilog/controlSequencer.sv
verilog/aluShiftControl.sv
verilog/writebackControl.sv
verilog/mipsControlUnit.sv
verification/clkGen.sv
verification/controlUnit_sva.sv
verification/controlUnitTb.sv

// ==== Bender.yml ====
package:
  name: mips_control_unit

sources:
  - files:
      - verilog/mipsCtrlPkg.sv
      - verilog/ctrlIfs.sv
      - verilog/instrDecoder.sv
      - verilog/controlSequencer.sv
      - verilog/aluShiftControl.sv
      - verilog/writebackControl.sv
      - verilog/mipsControlUnit.sv
  - target: test
    files:
      - verification/clkGen.sv
      - verification/controlUnit_sva.sv
      - verification/controlUnitTb.sv
